// File: logic/FetchPkg.sv
`default_nettype none

package FetchPkg;

    // Halfwords per 64-bit fetch block
    localparam int BLOCK_HALVES = 4;

    // Halfword offset inside a block
    typedef logic [1:0] FetchOff;

    // Byte address divided by 8
    typedef logic [28:0] BlockAddr;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic [BLOCK_HALVES-1:0][15:0] halves;
        BlockAddr addr;
        // First halfword that belongs to the stream after a redirect
        FetchOff firstValid;
    } FetchBlock;

endpackage

`default_nettype wire

// File: logic/InstrPkg.sv
`default_nettype none

package InstrPkg;

    // Instructions handed to the decoder per cycle
    localparam int NUM_INSTRS = 2;

    typedef enum logic [2:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_LOAD,
        CLS_STORE
    } InstrClass;

    typedef struct packed {
        // Upper half is zero for compressed instructions
        logic [31:0] instr;
        logic [31:0] pc;
        logic is16bit;
        InstrClass cls;
        logic valid;
    } AlignedInstr;

    typedef AlignedInstr [NUM_INSTRS-1:0] InstrGroup;

endpackage

`default_nettype wire

// File: logic/PriorityEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module PriorityEncoder #(
    parameter int WIDTH = 8,
    parameter int COUNT = 2
) (
    input wire [WIDTH-1:0] data,
    output logic [COUNT-1:0][$clog2(WIDTH)-1:0] idx,
    output logic [COUNT-1:0] idxValid
);
    localparam int IDX_W = $clog2(WIDTH);

    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = data;
        for (int c = 0; c < COUNT; c++) begin
            idx[c] = '0;
            idxValid[c] = 1'b0;
            // Scan downwards so the lowest set bit wins
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    idx[c] = IDX_W'(i);
                    idxValid[c] = 1'b1;
                end
            end
            if (idxValid[c]) begin
                remaining[idx[c]] = 1'b0;
            end
        end
    end

    always_comb begin
        for (int c = 1; c < COUNT; c++) begin
            assert (!idxValid[c] || (idxValid[c-1] && idx[c-1] < idx[c]))
                else $error("PriorityEncoder: lane %0d index not above lane %0d", c, c - 1);
        end
    end

endmodule

`default_nettype wire

// File: logic/StageReg.sv
`timescale 1ns/1ps
`default_nettype none

module StageReg #(
    parameter type T = logic
) (
    input wire clk,
    input wire rst,
    input wire clear,
    input wire inValid,
    input wire T inData,
    output logic inReady,
    output logic outValid,
    output T outData,
    input wire outReady
);

    // Space when empty or when the held entry leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (clear) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= inData;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> $stable(outData))
        else $error("StageReg: payload changed while stalled");

endmodule

`default_nettype wire

// File: logic/FetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module FetchUnit (
    input wire clk,
    input wire rst,
    input wire redirect,
    input wire [31:0] redirectPc,
    output logic [31:0] wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input wire [31:0] wbDat,
    input wire wbAck,
    output logic blkValid,
    output FetchPkg::FetchBlock blkData,
    input wire blkReady
);
    typedef enum logic [2:0] {
        IDLE,
        READ_LO,
        READ_HI,
        HOLD,
        DRAIN
    } FetchState;

    FetchState state;
    FetchPkg::BlockAddr blkAddr;
    FetchPkg::FetchOff firstOff;
    logic [31:0] loWord;
    logic [31:0] hiWord;
    logic readDone;

    assign readDone = wbStb && wbAck;
    assign wbCyc = wbStb;

    // Block is offered straight from the bus on the second ack
    assign blkValid = (state == HOLD) || (state == READ_HI && readDone);

    always_comb begin
        blkData.halves = {(state == HOLD) ? hiWord : wbDat, loWord};
        blkData.addr = blkAddr;
        blkData.firstValid = firstOff;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            wbStb <= 1'b0;
            wbAdr <= '0;
            blkAddr <= FetchPkg::RESET_PC[31:3];
            firstOff <= FetchPkg::RESET_PC[2:1];
        end else if (redirect) begin
            blkAddr <= redirectPc[31:3];
            firstOff <= redirectPc[2:1];
            // An open read must still finish on the bus
            if (wbStb && !wbAck) begin
                state <= DRAIN;
            end else begin
                wbStb <= 1'b0;
                state <= IDLE;
            end
        end else begin
            case (state)
                IDLE: begin
                    wbStb <= 1'b1;
                    wbAdr <= {blkAddr, 3'b000};
                    state <= READ_LO;
                end
                READ_LO: begin
                    if (readDone) begin
                        wbStb <= 1'b0;
                        state <= READ_HI;
                    end
                end
                READ_HI: begin
                    if (!wbStb) begin
                        wbStb <= 1'b1;
                        wbAdr <= {blkAddr, 3'b100};
                    end else if (wbAck) begin
                        wbStb <= 1'b0;
                        if (blkReady) begin
                            blkAddr <= blkAddr + 1'b1;
                            firstOff <= '0;
                            state <= IDLE;
                        end else begin
                            state <= HOLD;
                        end
                    end
                end
                HOLD: begin
                    if (blkReady) begin
                        blkAddr <= blkAddr + 1'b1;
                        firstOff <= '0;
                        state <= IDLE;
                    end
                end
                DRAIN: begin
                    if (wbAck) begin
                        wbStb <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (readDone && state == READ_LO) begin
            loWord <= wbDat;
        end
        if (readDone && state == READ_HI) begin
            hiWord <= wbDat;
        end
    end

    // Wishbone classic: request held with a fixed address until ack
    assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr))
        else $error("FetchUnit: bus request dropped or moved before ack");

endmodule

`default_nettype wire

// File: logic/InstrAligner.sv
`timescale 1ns/1ps
`default_nettype none

module InstrAligner (
    input wire clk,
    input wire rst,
    input wire clear,
    input wire inValid,
    input wire FetchPkg::FetchBlock inBlock,
    output logic accept,
    output InstrPkg::InstrGroup group,
    input wire groupReady
);
    localparam int HALVES = FetchPkg::BLOCK_HALVES;
    localparam int WIN = 2 * HALVES;
    localparam int IDX_W = $clog2(WIN);

    logic [HALVES-1:0][15:0] histHalves;
    FetchPkg::BlockAddr histAddr;
    logic [HALVES-1:0] histStart;
    // Last accepted block ended with the low half of a 32-bit instruction
    logic histEndSplit;

    logic [HALVES-1:0] curStart;
    logic [WIN-1:0][15:0] win;
    logic [WIN-1:0] winIs32;
    logic [WIN-1:0] rawStart;
    logic [WIN-1:0] selStart;
    logic [WIN-1:0] consumed;
    logic [WIN-1:0] remaining;
    logic [InstrPkg::NUM_INSTRS-1:0][IDX_W-1:0] selIdx;
    logic [InstrPkg::NUM_INSTRS-1:0] selValid;

    // Walk the current block for instruction boundaries
    always_comb begin
        logic startOk;
        startOk = !histEndSplit;
        curStart = '0;
        for (int i = 0; i < HALVES; i++) begin
            if (inValid && startOk && i >= int'(inBlock.firstValid)) begin
                curStart[i] = 1'b1;
                startOk = inBlock.halves[i][1:0] != 2'b11;
            end else begin
                startOk = 1'b1;
            end
        end
    end

    always_comb begin
        win = {inBlock.halves, histHalves};
        for (int j = 0; j < WIN; j++) begin
            winIs32[j] = win[j][1:0] == 2'b11;
        end
        rawStart = {curStart, histStart};
        selStart = rawStart;
        // 32-bit starts wait here until their upper half is in the window
        if (winIs32[WIN-1]) begin
            selStart[WIN-1] = 1'b0;
        end
        if (!inValid && winIs32[HALVES-1]) begin
            selStart[HALVES-1] = 1'b0;
        end
    end

    PriorityEncoder #(
        .WIDTH(WIN),
        .COUNT(InstrPkg::NUM_INSTRS)
    ) startEnc (
        .data(selStart),
        .idx(selIdx),
        .idxValid(selValid)
    );

    always_comb begin
        logic [IDX_W-1:0] pos;
        group = '0;
        consumed = '0;
        for (int k = 0; k < InstrPkg::NUM_INSTRS; k++) begin
            pos = selIdx[k];
            if (selValid[k]) begin
                group[k].instr = {winIs32[pos] ? win[pos + IDX_W'(1)] : 16'h0000, win[pos]};
                group[k].pc = {pos[IDX_W-1] ? inBlock.addr : histAddr, pos[IDX_W-2:0], 1'b0};
                group[k].is16bit = !winIs32[pos];
                group[k].cls = InstrPkg::CLS_OTHER;
                group[k].valid = 1'b1;
                if (groupReady) begin
                    consumed[pos] = 1'b1;
                end
            end
        end
    end

    assign remaining = rawStart & ~consumed;

    // New block only once the history is fully handed out
    assign accept = !(|remaining[HALVES-1:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            histStart <= '0;
            histEndSplit <= 1'b0;
        end else if (clear) begin
            histStart <= '0;
            histEndSplit <= 1'b0;
        end else if (inValid && accept) begin
            histStart <= remaining[WIN-1:HALVES];
            histEndSplit <= curStart[HALVES-1] && winIs32[WIN-1];
        end else begin
            histStart <= remaining[HALVES-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && accept) begin
            histHalves <= inBlock.halves;
            histAddr <= inBlock.addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/PreDecode.sv
`timescale 1ns/1ps
`default_nettype none

module PreDecode (
    input wire InstrPkg::InstrGroup inGroup,
    output InstrPkg::InstrGroup outGroup
);

    function automatic InstrPkg::InstrClass classify(input logic [31:0] instr, input logic is16);
        logic [1:0] quad;
        logic [2:0] funct3;
        InstrPkg::InstrClass cls;
        quad = instr[1:0];
        funct3 = instr[15:13];
        cls = InstrPkg::CLS_OTHER;
        if (!is16) begin
            case (instr[6:0])
                7'b1100011: cls = InstrPkg::CLS_BRANCH;
                7'b1101111, 7'b1100111: cls = InstrPkg::CLS_JUMP;
                7'b0000011: cls = InstrPkg::CLS_LOAD;
                7'b0100011: cls = InstrPkg::CLS_STORE;
                default: cls = InstrPkg::CLS_OTHER;
            endcase
        end else if (quad == 2'b01) begin
            // c.jal, c.j, c.beqz, c.bnez
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                cls = InstrPkg::CLS_JUMP;
            end else if (funct3 == 3'b110 || funct3 == 3'b111) begin
                cls = InstrPkg::CLS_BRANCH;
            end
        end else begin
            // Quadrants 00 and 10 share the lw/sw encodings
            if (funct3 == 3'b010) begin
                cls = InstrPkg::CLS_LOAD;
            end else if (funct3 == 3'b110) begin
                cls = InstrPkg::CLS_STORE;
            end
        end
        return cls;
    endfunction

    always_comb begin
        outGroup = inGroup;
        for (int k = 0; k < InstrPkg::NUM_INSTRS; k++) begin
            outGroup[k].cls = classify(inGroup[k].instr, inGroup[k].is16bit);
        end
    end

endmodule

`default_nettype wire

// File: logic/Frontend.sv
`timescale 1ns/1ps
`default_nettype none

module Frontend (
    input wire clk,
    input wire rst,
    input wire redirect,
    input wire [31:0] redirectPc,
    output logic [31:0] wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input wire [31:0] wbDat,
    input wire wbAck,
    output logic [InstrPkg::NUM_INSTRS-1:0] outValid,
    output logic [InstrPkg::NUM_INSTRS-1:0][31:0] outPc,
    output logic [InstrPkg::NUM_INSTRS-1:0][31:0] outInstr,
    output logic [InstrPkg::NUM_INSTRS-1:0] outIs16bit,
    output InstrPkg::InstrClass [InstrPkg::NUM_INSTRS-1:0] outClass,
    input wire outReady
);
    logic fetchValid;
    FetchPkg::FetchBlock fetchBlock;
    logic fetchReady;
    logic blkValid;
    FetchPkg::FetchBlock blkData;
    logic blkAccept;
    InstrPkg::InstrGroup alignedGroup;
    InstrPkg::InstrGroup decodedGroup;
    logic groupReady;
    logic grpValid;
    InstrPkg::InstrGroup grpData;

    FetchUnit fetch (
        .clk(clk), .rst(rst), .redirect(redirect), .redirectPc(redirectPc),
        .wbAdr(wbAdr), .wbCyc(wbCyc), .wbStb(wbStb), .wbDat(wbDat), .wbAck(wbAck),
        .blkValid(fetchValid), .blkData(fetchBlock), .blkReady(fetchReady)
    );

    StageReg #(.T(FetchPkg::FetchBlock)) blockReg (
        .clk(clk), .rst(rst), .clear(redirect),
        .inValid(fetchValid), .inData(fetchBlock), .inReady(fetchReady),
        .outValid(blkValid), .outData(blkData), .outReady(blkAccept)
    );

    InstrAligner align (
        .clk(clk), .rst(rst), .clear(redirect),
        .inValid(blkValid), .inBlock(blkData), .accept(blkAccept),
        .group(alignedGroup), .groupReady(groupReady)
    );

    PreDecode predec (
        .inGroup(alignedGroup),
        .outGroup(decodedGroup)
    );

    // Lane 0 is always filled first
    StageReg #(.T(InstrPkg::InstrGroup)) outReg (
        .clk(clk), .rst(rst), .clear(redirect),
        .inValid(decodedGroup[0].valid), .inData(decodedGroup), .inReady(groupReady),
        .outValid(grpValid), .outData(grpData), .outReady(outReady)
    );

    for (genvar k = 0; k < InstrPkg::NUM_INSTRS; k++) begin : lane
        assign outValid[k] = grpValid && grpData[k].valid;
        assign outPc[k] = grpData[k].pc;
        assign outInstr[k] = grpData[k].instr;
        assign outIs16bit[k] = grpData[k].is16bit;
        assign outClass[k] = grpData[k].cls;
    end

endmodule

`default_nettype wire

// File: tb/WbRom.sv
`timescale 1ns/1ps
`default_nettype none

module WbRom #(
    parameter int WORDS = 256
) (
    input wire clk,
    input wire rst,
    input wire [31:0] adr,
    input wire cyc,
    input wire stb,
    output logic [31:0] dat,
    output logic ack
);
    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [0:WORDS-1];
    integer seed;

    initial begin
        seed = 18691;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = $random(seed);
        end
    end

    // One wait state, ack drops together with stb
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
            dat <= '0;
        end else begin
            ack <= cyc && stb && !ack;
            // Upper address bits ignored so the memory wraps
            dat <= mem[adr[AW+1:2]];
        end
    end

endmodule

`default_nettype wire

// File: tb/FrontendTb.sv
`timescale 1ns/1ps
`default_nettype none

module FrontendTb;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RESET_TAIL = 4;
    localparam int SEQ_CYCLES = 400;
    localparam int BP_CYCLES = 200;
    localparam int NUM_REDIRECTS = 5;
    localparam int REDIR_CYCLES = 60;
    localparam int TEST_CYCLES = RESET_CYCLES + RESET_TAIL + SEQ_CYCLES + BP_CYCLES
        + NUM_REDIRECTS * (REDIR_CYCLES + 2);
    localparam int NUM = InstrPkg::NUM_INSTRS;

    logic clk;
    logic rst;
    logic redirect;
    logic [31:0] redirectPc;
    logic [31:0] wbAdr;
    logic wbCyc;
    logic wbStb;
    logic [31:0] wbDat;
    logic wbAck;
    logic [NUM-1:0] outValid;
    logic [NUM-1:0][31:0] outPc;
    logic [NUM-1:0][31:0] outInstr;
    logic [NUM-1:0] outIs16bit;
    InstrPkg::InstrClass [NUM-1:0] outClass;
    logic outReady;

    integer seed;
    int errorCount = 0;
    int lanesTaken = 0;
    int redirHits = 0;
    int errMark = 0;
    int laneMark = 0;
    logic [31:0] expPc;
    logic [31:0] redirTarget;
    logic redirPending;

    Frontend Frontend_inst (
        .clk(clk), .rst(rst), .redirect(redirect), .redirectPc(redirectPc),
        .wbAdr(wbAdr), .wbCyc(wbCyc), .wbStb(wbStb), .wbDat(wbDat), .wbAck(wbAck),
        .outValid(outValid), .outPc(outPc), .outInstr(outInstr),
        .outIs16bit(outIs16bit), .outClass(outClass), .outReady(outReady)
    );

    WbRom rom (
        .clk(clk), .rst(rst), .adr(wbAdr), .cyc(wbCyc), .stb(wbStb),
        .dat(wbDat), .ack(wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] halfAt(input logic [31:0] pc);
        logic [31:0] word;
        word = rom.mem[pc[9:2]];
        return pc[1] ? word[31:16] : word[15:0];
    endfunction

    function automatic logic isCompressed(input logic [31:0] pc);
        logic [15:0] half;
        half = halfAt(pc);
        return half[1:0] != 2'b11;
    endfunction

    function automatic logic [31:0] nextPc(input logic [31:0] pc);
        return isCompressed(pc) ? pc + 32'd2 : pc + 32'd4;
    endfunction

    function automatic logic [31:0] instrAt(input logic [31:0] pc);
        if (isCompressed(pc)) begin
            return {16'h0000, halfAt(pc)};
        end
        return {halfAt(pc + 32'd2), halfAt(pc)};
    endfunction

    function automatic InstrPkg::InstrClass expectedClass(input logic [31:0] pc);
        logic [31:0] instr;
        logic [2:0] f3;
        instr = instrAt(pc);
        f3 = instr[15:13];
        if (!isCompressed(pc)) begin
            if (instr[6:0] == 7'h63) return InstrPkg::CLS_BRANCH;
            if (instr[6:0] == 7'h6F || instr[6:0] == 7'h67) return InstrPkg::CLS_JUMP;
            if (instr[6:0] == 7'h03) return InstrPkg::CLS_LOAD;
            if (instr[6:0] == 7'h23) return InstrPkg::CLS_STORE;
            return InstrPkg::CLS_OTHER;
        end
        if (instr[1:0] == 2'b01) begin
            if (f3 == 3'b001 || f3 == 3'b101) return InstrPkg::CLS_JUMP;
            if (f3 == 3'b110 || f3 == 3'b111) return InstrPkg::CLS_BRANCH;
            return InstrPkg::CLS_OTHER;
        end
        if (f3 == 3'b010) return InstrPkg::CLS_LOAD;
        if (f3 == 3'b110) return InstrPkg::CLS_STORE;
        return InstrPkg::CLS_OTHER;
    endfunction

    task automatic flagError(input string msg);
        errorCount++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic stepCycles(input int n, input int readyPct);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #5;
            outReady = ({$random(seed)} % 100) < readyPct;
        end
    endtask

    task automatic redirectTo(input logic [31:0] target);
        @(posedge clk);
        #5;
        redirect = 1'b1;
        redirectPc = target;
        @(posedge clk);
        #5;
        redirect = 1'b0;
    endtask

    task automatic reportTest(input string name);
        $display("test %-16s lanes %0d errors %0d", name, lanesTaken - laneMark,
            errorCount - errMark);
        laneMark = lanesTaken;
        errMark = errorCount;
    endtask

    // Reference walk, advanced only by lanes the consumer takes
    always @(posedge clk or posedge rst) begin
        logic [31:0] pc;
        if (rst) begin
            expPc <= FetchPkg::RESET_PC;
            redirPending <= 1'b0;
            redirTarget <= '0;
        end else if (redirect) begin
            expPc <= redirectPc;
            redirPending <= 1'b1;
            redirTarget <= redirectPc;
        end else begin
            pc = expPc;
            if (outReady) begin
                for (int k = 0; k < NUM; k++) begin
                    if (outValid[k]) begin
                        pc = nextPc(pc);
                        lanesTaken++;
                    end
                end
            end
            expPc <= pc;
            if (redirPending && outValid[0]) begin
                redirHits++;
                redirPending <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) rst && $past(rst) |-> outValid == '0 && !wbCyc)
        else flagError("outputs or bus active during reset");
    assert property (@(posedge clk) $fell(rst) |-> outValid == '0 && !wbCyc)
        else flagError("outputs or bus active on the edge after reset");
    assert property (@(posedge clk) $fell(rst) |=> wbCyc)
        else flagError("bus cycle did not start in the first cycle after reset");

    assert property (@(posedge clk) disable iff (rst)
        outValid[0] |-> outPc[0] == expPc && outInstr[0] == instrAt(expPc)
            && outIs16bit[0] == isCompressed(expPc))
        else flagError($sformatf("lane 0 differs from reference at pc %h", expPc));
    assert property (@(posedge clk) disable iff (rst)
        outValid[1] |-> outValid[0] && outPc[1] == nextPc(expPc)
            && outInstr[1] == instrAt(nextPc(expPc))
            && outIs16bit[1] == isCompressed(nextPc(expPc)))
        else flagError($sformatf("lane 1 differs from reference at pc %h", nextPc(expPc)));

    assert property (@(posedge clk) disable iff (rst)
        outValid[0] |-> outClass[0] == expectedClass(expPc))
        else flagError($sformatf("lane 0 class wrong at pc %h", expPc));
    assert property (@(posedge clk) disable iff (rst)
        outValid[1] |-> outClass[1] == expectedClass(nextPc(expPc)))
        else flagError($sformatf("lane 1 class wrong at pc %h", nextPc(expPc)));

    // Stalled outputs must not move unless a redirect flushes them
    assert property (@(posedge clk) disable iff (rst)
        outValid[0] && !outReady && !redirect |=> $stable(outValid) && $stable(outPc)
            && $stable(outInstr) && $stable(outIs16bit) && $stable(outClass))
        else flagError("outputs changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        redirPending && outValid[0] |-> outPc[0] == redirTarget)
        else flagError($sformatf("first pc after redirect is not %h", redirTarget));

    assert property (@(posedge clk) disable iff (rst)
        wbStb |-> wbCyc && wbAdr[1:0] == 2'b00)
        else flagError("bus strobe without cycle or misaligned address");
    assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr))
        else flagError("bus request dropped or address moved before ack");

    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 6 / 5);
        $display("Run timed out before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] target;
        seed = 18691;
        rst = 1'b1;
        redirect = 1'b0;
        redirectPc = '0;
        outReady = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;
        stepCycles(RESET_TAIL, 75);
        reportTest("reset check");

        stepCycles(SEQ_CYCLES, 75);
        if (lanesTaken == laneMark) begin
            flagError("no instructions were delivered during the sequential stream");
        end
        reportTest("sequential");

        stepCycles(BP_CYCLES, 25);
        if (lanesTaken == laneMark) begin
            flagError("no instructions were delivered under back-pressure");
        end
        reportTest("back-pressure");

        for (int r = 0; r < NUM_REDIRECTS; r++) begin
            target = {$random(seed)} & 32'h0000_03FE;
            redirectTo(target);
            stepCycles(REDIR_CYCLES, 75);
        end
        if (redirHits != NUM_REDIRECTS) begin
            flagError($sformatf("only %0d of %0d redirects delivered an instruction",
                redirHits, NUM_REDIRECTS));
        end
        reportTest("redirects");

        $display("tests 4, lanes %0d, redirects hit %0d, errors %0d", lanesTaken, redirHits,
            errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
logic/FetchPkg.sv
logic/InstrPkg.sv
logic/PriorityEncoder.sv
logic/StageReg.sv
logic/FetchUnit.sv
logic/InstrAligner.sv
logic/PreDecode.sv
logic/Frontend.sv
tb/WbRom.sv
tb/FrontendTb.sv

// File: Makefile
SIM ?= verilator
TOP ?= FrontendTb
VFLAGS ?= --binary --timing --assert -j 0
BUILD_DIR ?= obj_dir
FILELIST ?= src.f

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf $(BUILD_DIR)
